// File: rtl/corePkg.sv
`default_nettype none

package corePkg;

    // datapath and instruction width
    localparam int XLEN = 32;
    // register index width and register count
    localparam int REG_IDX = 5;
    localparam int AMT_REG = 32;

    // word-addressed program storage
    localparam int MEM_ADDR_BITS = 6;
    localparam int MEM_DEPTH = 64;

    // the two major opcodes still decoded
    typedef enum logic [6:0] {
        OPC_OP    = 7'b0110011,
        OPC_OPIMM = 7'b0010011
    } opcode_t;

    // one state per instruction phase
    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK
    } ctrlState_t;

    typedef enum logic [3:0] {
        ADD, SUB, XOR, OR, AND, SLT, SLTU, SLL, SRL, SRA
    } aluOp_t;

    // decoded operation, held from DECODE until writeback
    typedef struct packed {
        aluOp_t               aluOp;
        logic [REG_IDX-1:0]   rd;
        logic [REG_IDX-1:0]   rs1;
        logic [REG_IDX-1:0]   rs2;
        logic [XLEN-1:0]      imm;
        logic                 useImm;
        logic                 wrEn;
    } decodedOp_t;

    // register write as seen outside the core
    typedef struct packed {
        logic                 en;
        logic [REG_IDX-1:0]   idx;
        logic [XLEN-1:0]      val;
    } regWrite_t;

    // program load port into instruction storage
    typedef struct packed {
        logic                     en;
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [XLEN-1:0]          data;
    } progWrite_t;

endpackage

`default_nettype wire

// File: rtl/instrMem.sv
`timescale 1ns/10ps
`default_nettype none

module instrMem (
    input  logic                                clk,
    input  logic                                rst,
    input  corePkg::progWrite_t                 progWrite,
    input  logic [corePkg::MEM_ADDR_BITS-1:0]   rdAddr,
    input  logic                                memRdEn,
    output logic [corePkg::XLEN-1:0]            instr
);
    import corePkg::*;

    // one word per instruction
    logic [XLEN-1:0] mem [MEM_DEPTH];

    // program load port, open at any time
    always_ff @(posedge clk) begin
        if (progWrite.en) begin
            mem[progWrite.addr] <= progWrite.data;
        end
    end

    // registered read, word shows up the cycle after memRdEn
    // a same-cycle write to rdAddr returns the old word
    always_ff @(posedge clk) begin
        if (rst) begin
            // all-zero word decodes as unknown, so no stray write
            instr <= '0;
        end else if (memRdEn) begin
            instr <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

// File: rtl/pcCounter.sv
`timescale 1ns/10ps
`default_nettype none

module pcCounter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                step,
    output logic [corePkg::MEM_ADDR_BITS-1:0]   pc
);
    import corePkg::*;

    // word address, one step per retired instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (step) begin
            // wrap at the top of storage so the program loops
            if (pc == MEM_ADDR_BITS'(MEM_DEPTH - 1)) begin
                pc <= '0;
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/coreCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module coreCtrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    output corePkg::ctrlState_t state,
    output logic                memRdEn,
    output logic                irLoad,
    output logic                opLoad,
    output logic                resLoad,
    output logic                wbEn,
    output logic                step
);
    import corePkg::*;

    ctrlState_t stateNext;

    // fixed four-phase walk, run only gates the start of an instruction
    always_comb begin
        stateNext = state;
        case (state)
            FETCH: begin
                // hold here while run is low
                if (run) begin
                    stateNext = DECODE;
                end
            end
            DECODE: begin
                stateNext = EXECUTE;
            end
            EXECUTE: begin
                stateNext = WRITEBACK;
            end
            default: begin
                stateNext = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= stateNext;
        end
    end

    // read only when the instruction actually starts
    assign memRdEn = (state == FETCH) && run;
    // decode phase latches the raw word and its decoded op together
    assign irLoad  = (state == DECODE);
    assign opLoad  = (state == DECODE);
    assign resLoad = (state == EXECUTE);
    assign wbEn    = (state == WRITEBACK);
    // pc moves on as the instruction retires
    assign step    = (state == WRITEBACK);

endmodule

`default_nettype wire

// File: rtl/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        opLoad,
    input  logic [corePkg::XLEN-1:0]    instr,
    output corePkg::decodedOp_t         op
);
    import corePkg::*;

    logic [2:0] funct3;
    logic       altBit;
    logic       isR;
    logic       known;
    decodedOp_t opNext;

    assign funct3 = instr[14:12];
    // funct7 bit 30 picks sub and arithmetic shift
    assign altBit = instr[30];
    assign isR    = (instr[6:0] == OPC_OP);

    always_comb begin
        opNext     = '0;
        opNext.rd  = instr[11:7];
        opNext.rs1 = instr[19:15];
        opNext.rs2 = instr[24:20];
        // I-type immediate, sign-extended from bit 31
        opNext.imm = {{(XLEN-12){instr[31]}}, instr[31:20]};

        // funct3 map shared by both forms
        case (funct3)
            3'b000:  opNext.aluOp = (isR && altBit) ? SUB : ADD;
            3'b001:  opNext.aluOp = SLL;
            3'b010:  opNext.aluOp = SLT;
            3'b011:  opNext.aluOp = SLTU;
            3'b100:  opNext.aluOp = XOR;
            3'b101:  opNext.aluOp = altBit ? SRA : SRL;
            3'b110:  opNext.aluOp = OR;
            default: opNext.aluOp = AND;
        endcase

        case (instr[6:0])
            OPC_OP: begin
                // bit 30 only legal on sub and sra
                known = !altBit || (funct3 == 3'b000) || (funct3 == 3'b101);
                opNext.useImm = 1'b0;
            end
            OPC_OPIMM: begin
                // addi has no sub form, bit 30 is just immediate there
                known = 1'b1;
                opNext.useImm = 1'b1;
            end
            default: begin
                known = 1'b0;
            end
        endcase

        // unknown words and rd 0 retire without a write
        opNext.wrEn = known && (opNext.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op <= '0;
        end else if (opLoad) begin
            op <= opNext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        resLoad,
    input  corePkg::decodedOp_t         op,
    input  logic [corePkg::XLEN-1:0]    rs1Val,
    input  logic [corePkg::XLEN-1:0]    rs2Val,
    output logic [corePkg::XLEN-1:0]    result
);
    import corePkg::*;

    logic [XLEN-1:0]         opB;
    logic [$clog2(XLEN)-1:0] shamt;
    logic [XLEN-1:0]         resNext;

    // immediate form or register form
    assign opB   = op.useImm ? op.imm : rs2Val;
    // shifts only look at the low 5 bits
    assign shamt = opB[$clog2(XLEN)-1:0];

    always_comb begin
        case (op.aluOp)
            ADD:     resNext = rs1Val + opB;
            SUB:     resNext = rs1Val - opB;
            XOR:     resNext = rs1Val ^ opB;
            OR:      resNext = rs1Val | opB;
            AND:     resNext = rs1Val & opB;
            SLT:     resNext = XLEN'($signed(rs1Val) < $signed(opB));
            SLTU:    resNext = XLEN'(rs1Val < opB);
            SLL:     resNext = rs1Val << shamt;
            SRL:     resNext = rs1Val >> shamt;
            SRA:     resNext = $unsigned($signed(rs1Val) >>> shamt);
            default: resNext = '0;
        endcase
    end

    // result held for the writeback phase
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (resLoad) begin
            result <= resNext;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wbEn,
    input  corePkg::decodedOp_t         op,
    input  logic [corePkg::XLEN-1:0]    result,
    output logic [corePkg::XLEN-1:0]    rs1Val,
    output logic [corePkg::XLEN-1:0]    rs2Val,
    output corePkg::regWrite_t          regWrite
);
    import corePkg::*;

    logic [XLEN-1:0] regs [AMT_REG];
    logic            wrStrobe;

    // decoder already drops rd 0 from wrEn
    assign wrStrobe = wbEn && op.wrEn;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < AMT_REG; i++) begin
                regs[i] <= '0;
            end
        end else if (wrStrobe && (op.rd != '0)) begin
            regs[op.rd] <= result;
        end
    end

    // x0 is hardwired to zero on both read ports
    assign rs1Val = (op.rs1 == '0) ? '0 : regs[op.rs1];
    assign rs2Val = (op.rs2 == '0) ? '0 : regs[op.rs2];

    // same strobe leaves the core
    assign regWrite = '{en: wrStrobe, idx: op.rd, val: result};

endmodule

`default_nettype wire

// File: rtl/core.sv
`timescale 1ns/10ps
`default_nettype none

module core (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  corePkg::progWrite_t progWrite,
    output corePkg::regWrite_t  regWrite
);
    import corePkg::*;

    // sequencer enables
    logic memRdEn;
    logic irLoad;
    logic opLoad;
    logic resLoad;
    logic wbEn;
    logic step;

    logic [MEM_ADDR_BITS-1:0] pc;
    logic [XLEN-1:0]          instr;
    logic [XLEN-1:0]          ir;
    logic [XLEN-1:0]          irNext;
    decodedOp_t               op;
    logic [XLEN-1:0]          rs1Val;
    logic [XLEN-1:0]          rs2Val;
    logic [XLEN-1:0]          result;

    // state output is only watched from outside
    coreCtrl ctrl0 (
        .clk     (clk),
        .rst     (rst),
        .run     (run),
        .state   (),
        .memRdEn (memRdEn),
        .irLoad  (irLoad),
        .opLoad  (opLoad),
        .resLoad (resLoad),
        .wbEn    (wbEn),
        .step    (step)
    );

    pcCounter pc0 (
        .clk  (clk),
        .rst  (rst),
        .step (step),
        .pc   (pc)
    );

    instrMem mem0 (
        .clk       (clk),
        .rst       (rst),
        .progWrite (progWrite),
        .rdAddr    (pc),
        .memRdEn   (memRdEn),
        .instr     (instr)
    );

    // instruction register, holds the word in flight
    // decoder sees the incoming word so the op is ready for EXECUTE
    assign irNext = irLoad ? instr : ir;

    always_ff @(posedge clk) begin
        ir <= irNext;
    end

    decoder dec0 (
        .clk    (clk),
        .rst    (rst),
        .opLoad (opLoad),
        .instr  (irNext),
        .op     (op)
    );

    alu alu0 (
        .clk     (clk),
        .rst     (rst),
        .resLoad (resLoad),
        .op      (op),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .result  (result)
    );

    regFile rf0 (
        .clk      (clk),
        .rst      (rst),
        .wbEn     (wbEn),
        .op       (op),
        .result   (result),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .regWrite (regWrite)
    );

endmodule

`default_nettype wire

// File: test/coreCtrl_props.sv
`timescale 1ns/10ps
`default_nettype none

module coreCtrlProps (
    input logic                clk,
    input logic                rst,
    input logic                run,
    input corePkg::ctrlState_t state,
    input logic                memRdEn,
    input logic                irLoad,
    input logic                opLoad,
    input logic                resLoad,
    input logic                wbEn,
    input logic                step
);
    import corePkg::*;

    // FETCH waits on run, the rest is a fixed walk
    fetchHold: assert property (@(posedge clk) disable iff (rst)
        (state == FETCH && !run) |=> (state == FETCH))
        else $error("sequencer left FETCH with run low");
    fetchGo: assert property (@(posedge clk) disable iff (rst)
        (state == FETCH && run) |=> (state == DECODE))
        else $error("sequencer did not start an instruction");
    decodeToExec: assert property (@(posedge clk) disable iff (rst)
        (state == DECODE) |=> (state == EXECUTE))
        else $error("sequencer broke the state order after DECODE");
    execToWb: assert property (@(posedge clk) disable iff (rst)
        (state == EXECUTE) |=> (state == WRITEBACK))
        else $error("sequencer broke the state order after EXECUTE");
    wbToFetch: assert property (@(posedge clk) disable iff (rst)
        (state == WRITEBACK) |=> (state == FETCH))
        else $error("sequencer broke the state order after WRITEBACK");

    // a word read from storage is always decoded next
    readThenDecode: assert property (@(posedge clk) disable iff (rst)
        memRdEn |=> (state == DECODE))
        else $error("instruction read without a decode after it");

    // writeback and pc step belong to WRITEBACK only, right after the result latch
    wbOnlyInWb: assert property (@(posedge clk) disable iff (rst)
        wbEn |-> (state == WRITEBACK) && $past(resLoad))
        else $error("wbEn outside WRITEBACK");
    stepOnlyInWb: assert property (@(posedge clk) disable iff (rst)
        step |-> (state == WRITEBACK) && $past(resLoad))
        else $error("step outside WRITEBACK");

    // nothing moves right after a reset cycle
    quietReset: assert property (@(posedge clk)
        rst |=> (state == FETCH) && !wbEn && !step && !resLoad && !irLoad && !opLoad)
        else $error("sequencer outputs active after reset");

endmodule

bind coreCtrl coreCtrlProps props0 (
    .clk     (clk),
    .rst     (rst),
    .run     (run),
    .state   (state),
    .memRdEn (memRdEn),
    .irLoad  (irLoad),
    .opLoad  (opLoad),
    .resLoad (resLoad),
    .wbEn    (wbEn),
    .step    (step)
);

`default_nettype wire

// File: test/tbCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbCore;
    import corePkg::*;

    localparam int SEED = 10092;
    localparam int PAUSE_CYCLES = 20;

    logic       clk;
    logic       rst;
    logic       run;
    progWrite_t progWrite;
    regWrite_t  regWrite;

    // program kept as fields, 0 unknown, 1 register form, 2 immediate form
    int          progKind [MEM_DEPTH];
    int          progOp [MEM_DEPTH];
    logic [4:0]  progRd [MEM_DEPTH];
    logic [4:0]  progRs1 [MEM_DEPTH];
    logic [4:0]  progRs2 [MEM_DEPTH];
    logic [11:0] progImm [MEM_DEPTH];
    logic [31:0] progWord [MEM_DEPTH];

    // reference model state
    logic [31:0] mRegs [32];
    int          mPc;

    logic [31:0] lfsr;
    int          valErrs;
    int          otherErrs;
    logic        aborted;

    core dut0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .progWrite (progWrite),
        .regWrite  (regWrite)
    );

    always #10 clk = ~clk;

    // galois step per bit, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        logic [31:0] z;
        r = randBits(5);
        z = randBits(3);
        // about one field in eight forced to x0
        return (z == '0) ? 5'd0 : r[4:0];
    endfunction

    // op numbering: add sub xor or and slt sltu sll srl sra
    function automatic logic [2:0] funct3Of(input int op);
        case (op)
            2:       return 3'd4;
            3:       return 3'd6;
            4:       return 3'd7;
            5:       return 3'd2;
            6:       return 3'd3;
            7:       return 3'd1;
            8, 9:    return 3'd5;
            default: return 3'd0;
        endcase
    endfunction

    // load, store, branch, jal
    function automatic logic [6:0] unknownOpc(input logic [1:0] sel);
        case (sel)
            2'd0:    return 7'b0000011;
            2'd1:    return 7'b0100011;
            2'd2:    return 7'b1100011;
            default: return 7'b1101111;
        endcase
    endfunction

    function automatic logic [31:0] refAlu(input int op, input logic [31:0] a,
                                           input logic [31:0] b);
        case (op)
            0:       return a + b;
            1:       return a - b;
            2:       return a ^ b;
            3:       return a | b;
            4:       return a & b;
            // signs differ, the negative one is smaller
            5:       return (a[31] != b[31]) ? {31'd0, a[31]}
                                             : ((a < b) ? 32'd1 : 32'd0);
            6:       return (a < b) ? 32'd1 : 32'd0;
            7:       return a << b[4:0];
            8:       return a >> b[4:0];
            // logical shift, then sign bit copied into the vacated top bits
            default: return (a >> b[4:0]) | (a[31] ? ~(32'hffffffff >> b[4:0]) : 32'd0);
        endcase
    endfunction

    task automatic buildProgram();
        logic [31:0] rnd;
        logic [31:0] sel;
        logic [2:0]  f3;
        logic        alt;
        for (int a = 0; a < MEM_DEPTH; a++) begin
            sel = randBits(4);
            rnd = randBits(4);
            progOp[a]  = int'(rnd) % 10;
            progRd[a]  = pickReg();
            progRs1[a] = pickReg();
            progRs2[a] = pickReg();
            rnd = randBits(12);
            progImm[a] = rnd[11:0];
            if (sel == '0) begin
                // roughly one word in sixteen is no ALU instruction
                rnd = randBits(27);
                progKind[a] = 0;
                progWord[a] = {rnd[24:0], unknownOpc(rnd[26:25])};
            end else if (sel < 8) begin
                progKind[a] = 1;
                f3 = funct3Of(progOp[a]);
                alt = (progOp[a] == 1) || (progOp[a] == 9);
                progWord[a] = {1'b0, alt, 5'b0, progRs2[a], progRs1[a], f3, progRd[a],
                               7'b0110011};
            end else begin
                progKind[a] = 2;
                // no immediate form of sub
                if (progOp[a] == 1) begin
                    progOp[a] = 0;
                end
                f3 = funct3Of(progOp[a]);
                if (progOp[a] >= 7) begin
                    // shamt form, bit 30 marks srai
                    alt = (progOp[a] == 9);
                    progImm[a] = {1'b0, alt, 5'b0, progImm[a][4:0]};
                end
                progWord[a] = {progImm[a], progRs1[a], f3, progRd[a], 7'b0010011};
            end
        end
    endtask

    // one instruction of the model, x0 never written so it reads zero
    task automatic modelStep(output logic wr, output logic [4:0] idx,
                             output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        a = mRegs[progRs1[mPc]];
        b = (progKind[mPc] == 2) ? {{20{progImm[mPc][11]}}, progImm[mPc]}
                                 : mRegs[progRs2[mPc]];
        idx = progRd[mPc];
        val = refAlu(progOp[mPc], a, b);
        wr = (progKind[mPc] != 0) && (idx != '0);
        if (wr) begin
            mRegs[idx] = val;
        end
        mPc = (mPc + 1) % MEM_DEPTH;
    endtask

    // count is instructions retired up to and including the write, 0 if none
    task automatic modelNextWrite(output logic [4:0] idx, output logic [31:0] val,
                                  output int count);
        logic wr;
        count = 0;
        wr = 1'b0;
        while (!wr && count < MEM_DEPTH) begin
            modelStep(wr, idx, val);
            count++;
        end
        if (!wr) begin
            count = 0;
        end
    endtask

    task automatic expectQuiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!regWrite.en) else begin
                valErrs++;
                $display("ERR %0t: write x%0d while the core should be idle",
                         $time, regWrite.idx);
            end
        end
    endtask

    // program goes in word by word with run low
    task automatic loadProgram();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            expectQuiet(1);
            progWrite.en   = 1'b1;
            progWrite.addr = MEM_ADDR_BITS'(a);
            progWrite.data = progWord[a];
        end
        expectQuiet(1);
        progWrite = '0;
    endtask

    // waited stays -1 when no strobe came within limit
    task automatic waitStrobe(input int limit, output int waited);
        waited = -1;
        for (int i = 1; i <= limit && waited < 0; i++) begin
            @(negedge clk);
            if (regWrite.en) begin
                waited = i;
            end
        end
    endtask

    task automatic expectWrite(input logic first);
        logic [4:0]  idx;
        logic [31:0] val;
        int          count;
        int          gap;
        int          waited;
        if (aborted) begin
            return;
        end
        modelNextWrite(idx, val, count);
        if (count == 0) begin
            $display("model found no register write in a whole pass over the program");
            otherErrs++;
            aborted = 1'b1;
            return;
        end
        // first write counted from the rise of run, not from a strobe
        gap = first ? 4 * count - 1 : 4 * count;
        waitStrobe(gap + 8, waited);
        if (waited < 0) begin
            $display("timeout: no register write within %0d cycles", gap + 8);
            otherErrs++;
            aborted = 1'b1;
            return;
        end
        assert (waited == gap) else begin
            valErrs++;
            $display("ERR %0t: write came after %0d cycles, expected %0d",
                     $time, waited, gap);
        end
        assert (regWrite.idx != '0) else begin
            valErrs++;
            $display("ERR %0t: write to x0 left the core", $time);
        end
        assert (regWrite.idx == idx && regWrite.val == val) else begin
            valErrs++;
            $display("ERR %0t: write x%0d=%08h, expected x%0d=%08h",
                     $time, regWrite.idx, regWrite.val, idx, val);
        end
    endtask

    task automatic runWrites(input int n);
        expectWrite(1'b1);
        for (int i = 1; i < n; i++) begin
            expectWrite(1'b0);
        end
    endtask

    // drop run some cycles after a strobe, hold, then raise it again
    task automatic pauseRun(input int delay);
        logic        wr;
        logic [4:0]  idx;
        logic [31:0] val;
        int          expAt;
        if (aborted) begin
            return;
        end
        expectQuiet(delay);
        run = 1'b0;
        expAt = -1;
        // from delay 2 on, the next instruction is already fetched and retires
        if (delay >= 2) begin
            modelStep(wr, idx, val);
            if (wr) begin
                expAt = 4 - delay;
            end
        end
        for (int i = 1; i <= PAUSE_CYCLES; i++) begin
            @(negedge clk);
            if (i == expAt) begin
                assert (regWrite.en && regWrite.idx == idx && regWrite.val == val) else begin
                    valErrs++;
                    $display("ERR %0t: in-flight write x%0d=%08h missing or wrong",
                             $time, idx, val);
                end
            end else begin
                assert (!regWrite.en) else begin
                    valErrs++;
                    $display("ERR %0t: write x%0d while run is low", $time, regWrite.idx);
                end
            end
        end
        run = 1'b1;
    endtask

    initial begin
        lfsr = 32'(SEED);
        clk = 1'b0;
        rst = 1'b1;
        run = 1'b0;
        progWrite = '0;
        valErrs = 0;
        otherErrs = 0;
        aborted = 1'b0;
        mPc = 0;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
        end

        // two reset cycles, then a quiet stretch with run low
        expectQuiet(2);
        rst = 1'b0;
        buildProgram();
        loadProgram();
        expectQuiet(6);

        // long run wraps past the last word
        run = 1'b1;
        runWrites(90);
        pauseRun(2);
        runWrites(30);
        pauseRun(0);
        runWrites(30);
        pauseRun(3);
        runWrites(20);

        $display("summary: %0d value errors, %0d other errors", valErrs, otherErrs);
        if (valErrs + otherErrs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/corePkg.sv
rtl/instrMem.sv
rtl/pcCounter.sv
rtl/coreCtrl.sv
rtl/decoder.sv
rtl/alu.sv
rtl/regFile.sv
rtl/core.sv
test/coreCtrl_props.sv
test/tbCore.sv

// File: Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tbCore
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard rtl/*.sv test/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "test: FAIL"; exit 1; \
	else \
		echo "test: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
